/* design/nf_datapath_params.svh */
`ifndef NF_DATAPATH_PARAMS_SVH
`define NF_DATAPATH_PARAMS_SVH

// stream word payload
`define DATA_WIDTH 64
`define KEEP_WIDTH 8

// output queue geometry
`define NUM_QUEUES 4
`define QUEUE_DEPTH 16

// occupancy count, holds 0 to QUEUE_DEPTH
`define QSIZE_WIDTH 5

// daisy chain, queue 1 re-enters the arbiter
`define LOOP_QUEUE 1

// looped packets always leave through nf0
`define LOOP_EXIT_QUEUE 0

`endif

/* design/nf_datapath_pkg.sv */
`include "nf_datapath_params.svh"

package nf_datapath_pkg;

    // output queue index
    typedef enum logic [1:0] {
        PORT_NF0 = 2'd0,
        PORT_NF1 = 2'd1,
        PORT_NF2 = 2'd2,
        PORT_NF3 = 2'd3
    } port_e;

    // one bit per port, even bits for the physical ports
    typedef enum logic [7:0] {
        SRC_RX0  = 8'b0000_0001,
        SRC_RX1  = 8'b0000_0100,
        SRC_LOOP = 8'b0100_0000
    } src_e;

    typedef enum logic {
        ARB_IDLE   = 1'b0,
        ARB_LOCKED = 1'b1
    } arb_state_e;

    // 31 bits of per-word metadata
    typedef struct packed {
        src_e                    src;
        port_e                   dst;
        logic [`QSIZE_WIDTH-1:0] qsize;
        logic [15:0]             len;
    } pkt_meta_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data;
        logic [`KEEP_WIDTH-1:0] keep;
        logic                   last;
        pkt_meta_t              meta;
    } axis_word_t;

endpackage

/* design/input_arbiter.sv */
`include "nf_datapath_params.svh"

module input_arbiter (
    input  logic                       axis_aclk,
    input  logic                       rst,

    input  nf_datapath_pkg::axis_word_t rx_0,
    input  logic                       rx_0_valid,
    output logic                       rx_0_ready,
    input  nf_datapath_pkg::axis_word_t rx_1,
    input  logic                       rx_1_valid,
    output logic                       rx_1_ready,
    input  nf_datapath_pkg::axis_word_t loop_word,
    input  logic                       loop_valid,
    output logic                       loop_ready,

    output nf_datapath_pkg::axis_word_t arb_word,
    output logic                       arb_valid,
    input  logic                       arb_ready
);
    import nf_datapath_pkg::*;

    // input index: 0 rx_0, 1 rx_1, 2 loopback
    arb_state_e state;
    logic [1:0] prio;
    logic [1:0] lock_sel;
    logic [1:0] pick;
    logic [1:0] sel;
    logic [1:0] sel_next;
    logic [2:0] req;
    logic       eop;

    assign req = {loop_valid, rx_1_valid, rx_0_valid};

    // first requester at or after prio, wrapping
    always_comb begin
        int idx;
        pick = prio;
        for (int i = 2; i >= 0; i--) begin
            idx = (int'(prio) + i) % 3;
            if (req[idx]) begin
                pick = 2'(idx);
            end
        end
    end

    assign sel      = (state == ARB_LOCKED) ? lock_sel : pick;
    assign sel_next = (sel == 2'd2) ? 2'd0 : sel + 2'd1;

    // pass-through of the chosen input, source tag rewritten
    always_comb begin
        case (sel)
            2'd0: begin
                arb_word          = rx_0;
                arb_valid         = rx_0_valid;
                arb_word.meta.src = SRC_RX0;
            end
            2'd1: begin
                arb_word          = rx_1;
                arb_valid         = rx_1_valid;
                arb_word.meta.src = SRC_RX1;
            end
            default: begin
                arb_word          = loop_word;
                arb_valid         = loop_valid;
                arb_word.meta.src = SRC_LOOP;
            end
        endcase
    end

    assign rx_0_ready = arb_ready && (sel == 2'd0);
    assign rx_1_ready = arb_ready && (sel == 2'd1);
    assign loop_ready = arb_ready && (sel == 2'd2);

    assign eop = arb_valid && arb_ready && arb_word.last;

    // lock as soon as a word is offered, so it stays put under back-pressure
    always_ff @(posedge axis_aclk) begin
        if (rst) begin
            state    <= ARB_IDLE;
            prio     <= 2'd0;
            lock_sel <= 2'd0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (arb_valid) begin
                        lock_sel <= pick;
                        if (eop) begin
                            prio <= sel_next;
                        end else begin
                            state <= ARB_LOCKED;
                        end
                    end
                end
                ARB_LOCKED: begin
                    if (eop) begin
                        state <= ARB_IDLE;
                        prio  <= sel_next;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

/* design/output_queues.sv */
`include "nf_datapath_params.svh"

module output_queues (
    input  logic                                      axis_aclk,
    input  logic                                      rst,

    input  logic [`NUM_QUEUES-1:0]                    push,
    input  nf_datapath_pkg::axis_word_t               push_word,
    output logic [`NUM_QUEUES-1:0]                    full,
    output logic [`NUM_QUEUES-1:0][`QSIZE_WIDTH-1:0]  qsize,

    // queue 1 goes back to the arbiter
    output nf_datapath_pkg::axis_word_t               loop_word,
    output logic                                      loop_valid,
    input  logic                                      loop_ready,

    output nf_datapath_pkg::axis_word_t               tx_0,
    output logic                                      tx_0_valid,
    input  logic                                      tx_0_ready,
    output nf_datapath_pkg::axis_word_t               tx_2,
    output logic                                      tx_2_valid,
    input  logic                                      tx_2_ready,
    output nf_datapath_pkg::axis_word_t               tx_3,
    output logic                                      tx_3_valid,
    input  logic                                      tx_3_ready
);
    import nf_datapath_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    axis_word_t             head [`NUM_QUEUES];
    logic [`NUM_QUEUES-1:0] head_valid;
    logic [`NUM_QUEUES-1:0] head_ready;

    // drain side of each queue
    assign head_ready[0]           = tx_0_ready;
    assign head_ready[`LOOP_QUEUE] = loop_ready;
    assign head_ready[2]           = tx_2_ready;
    assign head_ready[3]           = tx_3_ready;

    assign tx_0       = head[0];
    assign tx_0_valid = head_valid[0];
    assign loop_word  = head[`LOOP_QUEUE];
    assign loop_valid = head_valid[`LOOP_QUEUE];
    assign tx_2       = head[2];
    assign tx_2_valid = head_valid[2];
    assign tx_3       = head[3];
    assign tx_3_valid = head_valid[3];

    for (genvar q = 0; q < `NUM_QUEUES; q++) begin : g_queue
        axis_word_t              mem [`QUEUE_DEPTH];
        logic [PTR_W-1:0]        wr_ptr;
        logic [PTR_W-1:0]        rd_ptr;
        logic [`QSIZE_WIDTH-1:0] count;
        logic                    wr;
        logic                    rd;

        assign full[q]       = (count == `QSIZE_WIDTH'(`QUEUE_DEPTH));
        assign head_valid[q] = (count != '0);
        assign qsize[q]      = count;
        assign head[q]       = mem[rd_ptr];

        assign wr = push[q] && !full[q];
        assign rd = head_valid[q] && head_ready[q];

        always_ff @(posedge axis_aclk) begin
            if (wr) begin
                mem[wr_ptr] <= push_word;
            end
        end

        // push and pop may land in the same cycle
        always_ff @(posedge axis_aclk) begin
            if (rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (wr) begin
                    wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (rd) begin
                    rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                case ({wr, rd})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

endmodule

/* design/forward_stage.sv */
`include "nf_datapath_params.svh"

module forward_stage (
    input  logic                                      axis_aclk,
    input  logic                                      rst,

    input  nf_datapath_pkg::axis_word_t               arb_word,
    input  logic                                      arb_valid,
    output logic                                      arb_ready,

    input  logic [`NUM_QUEUES-1:0][`QSIZE_WIDTH-1:0]  qsize,
    input  logic [`NUM_QUEUES-1:0]                    full,
    output logic [`NUM_QUEUES-1:0]                    push,
    output nf_datapath_pkg::axis_word_t               push_word
);
    import nf_datapath_pkg::*;

    logic                    hold_valid;
    axis_word_t              hold_word;
    logic                    push_fire;
    logic                    accept;

    // per-packet decision, taken on the first word
    logic                    sof;
    port_e                   cur_dst;
    logic [`QSIZE_WIDTH-1:0] cur_qsize;
    port_e                   first_dst;
    port_e                   pick_dst;
    logic [`QSIZE_WIDTH-1:0] pick_qsize;

    assign push_fire = hold_valid && !full[hold_word.meta.dst];
    assign arb_ready = !hold_valid || push_fire;
    assign accept    = arb_valid && arb_ready;

    // looped packets exit on a fixed queue, others follow their dst
    always_comb begin
        if (arb_word.meta.src == SRC_LOOP) begin
            first_dst = port_e'(`LOOP_EXIT_QUEUE);
        end else begin
            first_dst = arb_word.meta.dst;
        end
        pick_dst   = sof ? first_dst : cur_dst;
        pick_qsize = sof ? qsize[first_dst] : cur_qsize;
    end

    always_comb begin
        push = '0;
        push[hold_word.meta.dst] = push_fire;
    end

    assign push_word = hold_word;

    always_ff @(posedge axis_aclk) begin
        if (rst) begin
            hold_valid <= 1'b0;
            sof        <= 1'b1;
            cur_dst    <= PORT_NF0;
            cur_qsize  <= '0;
        end else begin
            if (accept) begin
                hold_valid <= 1'b1;
                sof        <= arb_word.last;
                cur_dst    <= pick_dst;
                cur_qsize  <= pick_qsize;
            end else if (push_fire) begin
                hold_valid <= 1'b0;
            end
        end
    end

    // every word of a packet carries the same dst and qsize
    always_ff @(posedge axis_aclk) begin
        if (accept) begin
            hold_word            <= arb_word;
            hold_word.meta.dst   <= pick_dst;
            hold_word.meta.qsize <= pick_qsize;
        end
    end

endmodule

/* design/nf_datapath.sv */
`include "nf_datapath_params.svh"

module nf_datapath (
    input  logic                                      axis_aclk,
    input  logic                                      rst,

    // receive ports
    input  nf_datapath_pkg::axis_word_t               rx_0,
    input  logic                                      rx_0_valid,
    output logic                                      rx_0_ready,
    input  nf_datapath_pkg::axis_word_t               rx_1,
    input  logic                                      rx_1_valid,
    output logic                                      rx_1_ready,

    // transmit ports, nf1 is chained internally
    output nf_datapath_pkg::axis_word_t               tx_0,
    output logic                                      tx_0_valid,
    input  logic                                      tx_0_ready,
    output nf_datapath_pkg::axis_word_t               tx_2,
    output logic                                      tx_2_valid,
    input  logic                                      tx_2_ready,
    output nf_datapath_pkg::axis_word_t               tx_3,
    output logic                                      tx_3_valid,
    input  logic                                      tx_3_ready,

    output logic [`NUM_QUEUES-1:0][`QSIZE_WIDTH-1:0]  qsize
);
    import nf_datapath_pkg::*;

    axis_word_t             arb_word;
    logic                   arb_valid;
    logic                   arb_ready;

    axis_word_t             push_word;
    logic [`NUM_QUEUES-1:0] push;
    logic [`NUM_QUEUES-1:0] full;

    // daisy chain from queue 1 back into the arbiter
    axis_word_t             loop_word;
    logic                   loop_valid;
    logic                   loop_ready;

    input_arbiter u_input_arbiter (
        .axis_aclk  (axis_aclk),
        .rst        (rst),
        .rx_0       (rx_0),
        .rx_0_valid (rx_0_valid),
        .rx_0_ready (rx_0_ready),
        .rx_1       (rx_1),
        .rx_1_valid (rx_1_valid),
        .rx_1_ready (rx_1_ready),
        .loop_word  (loop_word),
        .loop_valid (loop_valid),
        .loop_ready (loop_ready),
        .arb_word   (arb_word),
        .arb_valid  (arb_valid),
        .arb_ready  (arb_ready)
    );

    forward_stage u_forward_stage (
        .axis_aclk (axis_aclk),
        .rst       (rst),
        .arb_word  (arb_word),
        .arb_valid (arb_valid),
        .arb_ready (arb_ready),
        .qsize     (qsize),
        .full      (full),
        .push      (push),
        .push_word (push_word)
    );

    output_queues u_output_queues (
        .axis_aclk  (axis_aclk),
        .rst        (rst),
        .push       (push),
        .push_word  (push_word),
        .full       (full),
        .qsize      (qsize),
        .loop_word  (loop_word),
        .loop_valid (loop_valid),
        .loop_ready (loop_ready),
        .tx_0       (tx_0),
        .tx_0_valid (tx_0_valid),
        .tx_0_ready (tx_0_ready),
        .tx_2       (tx_2),
        .tx_2_valid (tx_2_valid),
        .tx_2_ready (tx_2_ready),
        .tx_3       (tx_3),
        .tx_3_valid (tx_3_valid),
        .tx_3_ready (tx_3_ready)
    );

endmodule

/* sim/nf_datapath_properties.sv */
`include "nf_datapath_params.svh"

module nf_datapath_properties (
    input logic                                     axis_aclk,
    input logic                                     rst,
    input logic [`NUM_QUEUES-1:0]                   push,
    input logic [`NUM_QUEUES-1:0][`QSIZE_WIDTH-1:0] qsize
);
    timeunit 1ns;
    timeprecision 100ps;

    a_reset_clear: assert property (@(posedge axis_aclk) rst |=> qsize == '0)
        else $error("qsize %h not cleared by reset", qsize);

    for (genvar q = 0; q < `NUM_QUEUES; q++) begin : g_bound
        a_qsize_bound: assert property (@(posedge axis_aclk) disable iff (rst)
            qsize[q] <= `QUEUE_DEPTH)
            else $error("queue %0d occupancy %0d above depth", q, qsize[q]);

        // a pushed word is visible from the next cycle
        a_push_visible: assert property (@(posedge axis_aclk) disable iff (rst)
            push[q] |=> qsize[q] != '0)
            else $error("queue %0d still empty after a push", q);
    end

endmodule

bind forward_stage nf_datapath_properties u_fwd_props (
    .axis_aclk (axis_aclk),
    .rst       (rst),
    .push      (push),
    .qsize     (qsize)
);

bind output_queues nf_datapath_properties u_queue_props (
    .axis_aclk (axis_aclk),
    .rst       (rst),
    .push      (push),
    .qsize     (qsize)
);

/* sim/tb_nf_datapath.sv */
`include "nf_datapath_params.svh"

module tb_nf_datapath;
    timeunit 1ns;
    timeprecision 100ps;
    import nf_datapath_pkg::*;

    localparam int NUM_PKTS  = 200;
    localparam int MAX_WORDS = 6;
    localparam int READY_PCT = 75;
    localparam int VALID_PCT = 80;
    localparam int MARGIN    = 2000;
    localparam int TIMEOUT   = NUM_PKTS * MAX_WORDS * 8 + MARGIN;

    logic       axis_aclk = 1'b0;
    logic       rst;
    axis_word_t rx_w [2];
    logic [1:0] rx_v;
    wire  [1:0] rx_r;
    axis_word_t tx_w [4];
    wire  [3:0] tx_v;
    logic [3:0] tx_r;
    wire  [`NUM_QUEUES-1:0][`QSIZE_WIDTH-1:0] qsize;

    // stimulus per rx port, expected words per tx port and source
    axis_word_t              stim_q [2][$];
    axis_word_t              exp_q [4][3][$];
    logic [1:0]              fired;
    logic [3:0]              in_pkt;
    src_e                    pkt_src [4];
    logic [`QSIZE_WIDTH-1:0] pkt_qsize [4];
    logic                    running;
    integer                  seed;
    int                      errors;
    int                      rx_count;
    int                      tx_count;
    int                      total_words;
    int                      cycles;

    always #20 axis_aclk = ~axis_aclk;

    // nf1 has no tx port
    assign tx_v[1] = 1'b0;

    nf_datapath u_nf_datapath (
        .axis_aclk  (axis_aclk),
        .rst        (rst),
        .rx_0       (rx_w[0]),
        .rx_0_valid (rx_v[0]),
        .rx_0_ready (rx_r[0]),
        .rx_1       (rx_w[1]),
        .rx_1_valid (rx_v[1]),
        .rx_1_ready (rx_r[1]),
        .tx_0       (tx_w[0]),
        .tx_0_valid (tx_v[0]),
        .tx_0_ready (tx_r[0]),
        .tx_2       (tx_w[2]),
        .tx_2_valid (tx_v[2]),
        .tx_2_ready (tx_r[2]),
        .tx_3       (tx_w[3]),
        .tx_3_valid (tx_v[3]),
        .tx_3_ready (tx_r[3]),
        .qsize      (qsize)
    );

    function automatic int src_index(input src_e src);
        case (src)
            SRC_RX0:  return 0;
            SRC_RX1:  return 1;
            SRC_LOOP: return 2;
            default:  return -1;
        endcase
    endfunction

    task automatic compare_value(input string test, input logic [63:0] exp,
                                 input logic [63:0] act);
        assert (act === exp) else begin
            errors++;
            $display("ERR %s expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic check_idle(input string phase);
        compare_value({phase, " tx valid"}, 64'd0, {tx_v[3:2], tx_v[0]});
        compare_value({phase, " qsize"}, 64'd0, qsize);
    endtask

    task automatic build_stimulus();
        axis_word_t  w;
        int          p;
        int          n;
        port_e       dst;
        logic [15:0] len;
        for (int i = 0; i < NUM_PKTS; i++) begin
            p   = {$random(seed)} % 2;
            n   = 1 + {$random(seed)} % MAX_WORDS;
            dst = port_e'(2'($random(seed)));
            len = 16'($random(seed));
            for (int j = 0; j < n; j++) begin
                w.data       = {$random(seed), $random(seed)};
                w.keep       = 8'($random(seed));
                w.last       = (j == n - 1);
                // src and qsize are overwritten by the DUT
                w.meta.src   = src_e'(8'($random(seed)));
                w.meta.dst   = dst;
                w.meta.qsize = 5'($random(seed));
                w.meta.len   = len;
                stim_q[p].push_back(w);
                total_words++;
            end
        end
    endtask

    always @(negedge axis_aclk) begin : driver
        if (running) begin
            for (int p = 0; p < 2; p++) begin
                if (fired[p]) begin
                    void'(stim_q[p].pop_front());
                    rx_v[p]  = 1'b0;
                    fired[p] = 1'b0;
                end
                if (!rx_v[p] && stim_q[p].size() > 0 && ({$random(seed)} % 100) < VALID_PCT) begin
                    rx_w[p] = stim_q[p][0];
                    rx_v[p] = 1'b1;
                end
            end
            for (int k = 0; k < 4; k++) begin
                tx_r[k] = (k != 1) && (({$random(seed)} % 100) < READY_PCT);
            end
        end
    end

    always @(posedge axis_aclk) begin : monitor
        axis_word_t exp;
        axis_word_t got;
        int         port;
        int         s;
        string      test;
        if (!rst) begin
            // dst 1 packets come back on nf0 tagged as loopback
            for (int p = 0; p < 2; p++) begin
                if (rx_v[p] && rx_r[p]) begin
                    exp  = rx_w[p];
                    port = (exp.meta.dst == PORT_NF1) ? `LOOP_EXIT_QUEUE : int'(exp.meta.dst);
                    s    = (exp.meta.dst == PORT_NF1) ? 2 : p;
                    exp.meta.src = (s == 2) ? SRC_LOOP : ((p == 0) ? SRC_RX0 : SRC_RX1);
                    exp.meta.dst = port_e'(port);
                    exp_q[port][s].push_back(exp);
                    fired[p] = 1'b1;
                    rx_count++;
                end
            end
            for (int q = 0; q < `NUM_QUEUES; q++) begin
                assert (qsize[q] <= `QUEUE_DEPTH) else begin
                    errors++;
                    $display("ERR occupancy expected <= %0d actual %0d", `QUEUE_DEPTH, qsize[q]);
                end
            end
            for (int k = 0; k < 4; k++) begin
                if (tx_v[k] && tx_r[k]) begin
                    got = tx_w[k];
                    s   = src_index(got.meta.src);
                    tx_count++;
                    assert (s >= 0 && exp_q[k][s].size() > 0) else begin
                        errors++;
                        $display("tx_%0d delivered a word with src %h that was never sent there",
                                 k, got.meta.src);
                    end
                    if (s >= 0 && exp_q[k][s].size() > 0) begin
                        exp  = exp_q[k][s].pop_front();
                        test = (s == 2) ? "loopback" : "routing";
                        compare_value({test, " data"}, exp.data, got.data);
                        compare_value({test, " keep"}, exp.keep, got.keep);
                        compare_value({test, " last"}, exp.last, got.last);
                        compare_value({test, " len"}, exp.meta.len, got.meta.len);
                        compare_value({test, " src"}, exp.meta.src, got.meta.src);
                        compare_value({test, " dst"}, exp.meta.dst, got.meta.dst);
                    end
                    // whole packet shares one src and one stamped qsize
                    if (in_pkt[k]) begin
                        compare_value("atomicity src", pkt_src[k], got.meta.src);
                        compare_value("atomicity qsize", pkt_qsize[k], got.meta.qsize);
                    end else begin
                        pkt_src[k]   = got.meta.src;
                        pkt_qsize[k] = got.meta.qsize;
                    end
                    in_pkt[k] = !got.last;
                    assert (got.meta.qsize <= `QUEUE_DEPTH) else begin
                        errors++;
                        $display("ERR stamped qsize expected <= %0d actual %0d",
                                 `QUEUE_DEPTH, got.meta.qsize);
                    end
                end
            end
        end
    end

    always @(posedge axis_aclk) begin : watchdog
        cycles++;
        if (cycles > TIMEOUT) begin
            errors++;
            $display("timeout: only %0d of %0d words left the DUT within %0d cycles",
                     tx_count, total_words, TIMEOUT);
            $display("errors %0d, words sent %0d, words received %0d", errors, rx_count, tx_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        seed        = 32'h3b96;
        rst         = 1'b1;
        rx_w[0]     = '0;
        rx_w[1]     = '0;
        rx_v        = '0;
        tx_r        = '0;
        fired       = '0;
        in_pkt      = '0;
        running     = 1'b0;
        errors      = 0;
        rx_count    = 0;
        tx_count    = 0;
        total_words = 0;
        cycles      = 0;
        build_stimulus();
        repeat (8) begin
            @(negedge axis_aclk);
            check_idle("reset");
        end
        rst = 1'b0;
        @(negedge axis_aclk);
        check_idle("after reset");
        @(posedge axis_aclk);
        running = 1'b1;
        while (tx_count < total_words) begin
            @(negedge axis_aclk);
        end
        repeat (4) @(negedge axis_aclk);
        check_idle("drain");
        for (int k = 0; k < 4; k++) begin
            for (int s = 0; s < 3; s++) begin
                assert (exp_q[k][s].size() == 0) else begin
                    errors++;
                    $display("tx_%0d never delivered %0d words from source %0d",
                             k, exp_q[k][s].size(), s);
                end
            end
        end
        $display("errors %0d, words sent %0d, words received %0d", errors, rx_count, tx_count);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* nf_datapath.f */
+incdir+design
design/nf_datapath_pkg.sv
design/input_arbiter.sv
design/output_queues.sv
design/forward_stage.sv
design/nf_datapath.sv
sim/nf_datapath_properties.sv
sim/tb_nf_datapath.sv

/* Bender.yml */
package:
  name: nf_datapath

sources:
  - include_dirs:
      - design
    files:
      - design/nf_datapath_pkg.sv
      - design/input_arbiter.sv
      - design/output_queues.sv
      - design/forward_stage.sv
      - design/nf_datapath.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/nf_datapath_properties.sv
      - sim/tb_nf_datapath.sv
